// ==== hw/gng_cpu_consts.svh ====
`ifndef GNG_CPU_CONSTS_SVH
`define GNG_CPU_CONSTS_SVH

`define ADDR_W      16
`define DATA_W      8
`define BANK_W      3
`define EXT_ADDR_W  13
`define ROM_ADDR_W  17
`define REGION_W    3

`define RGN_WRAM    3'd0
`define RGN_EXT     3'd1
`define RGN_ROM     3'd2
`define RGN_OPEN    3'd3

`define ROM8N_BASE  17'h00000  // 8n/9n, 32 KB
`define ROM10N_BASE 17'h08000  // 10n, 16 KB
`define ROM10N_END  17'h0c000
`define ROM13N_BASE 17'h10000  // 13n/12n, 32 KB
`define ROM13N_END  17'h18000

`define OPEN_BUS_DATA 8'hff

`endif

// ==== hw/gng_cpu_pkg.sv ====
`include "gng_cpu_consts.svh"

package gng_cpu_pkg;

	// cpu address
	typedef logic [`ADDR_W-1:0] addr_t;

	// one bus byte
	typedef logic [`DATA_W-1:0] data_t;

	// bank register from the video board
	typedef logic [`BANK_W-1:0] bank_t;

	// board bus address, pins AB[12:0]
	typedef logic [`EXT_ADDR_W-1:0] ext_addr_t;

	// 8n/9n, 10n and 13n/12n in one space
	typedef logic [`ROM_ADDR_W-1:0] rom_addr_t;

	// decoded region, see RGN_* macros
	typedef logic [`REGION_W-1:0] region_t;

	// strobe fsm of the board bus driver
	typedef enum logic {
		ST_IDLE,
		ST_STROBE
	} bus_state_e;

endpackage

// ==== hw/gng_bus_if.sv ====
`timescale 1ns/1ps

// registered cpu request, capture to decode
interface gng_req_if import gng_cpu_pkg::*; ();
	logic  valid;  // one cycle per request
	addr_t addr;
	data_t wdata;
	logic  rnw;
	bank_t bank;

	modport src (
		output valid, addr, wdata, rnw, bank
	);

	modport dst (
		input valid, addr, wdata, rnw, bank
	);
endinterface

// decoded request, decode to bus driver
interface gng_dec_if import gng_cpu_pkg::*; ();
	logic      valid;
	region_t   region;
	rom_addr_t rom_addr;  // only meaningful for RGN_ROM
	ext_addr_t ext_addr;
	data_t     wdata;
	logic      rnw;

	modport src (
		output valid, region, rom_addr, ext_addr, wdata, rnw
	);

	modport dst (
		input valid, region, rom_addr, ext_addr, wdata, rnw
	);
endinterface

// ==== hw/cpu_bus_capture.sv ====
`timescale 1ns/1ps

module cpu_bus_capture
	import gng_cpu_pkg::*;
(
	input  logic g6m,
	input  logic rst_n,
	input  logic cpu_req,
	input  addr_t cpu_addr,
	input  data_t cpu_wdata,
	input  logic cpu_rnw,
	input  bank_t bank,
	input  logic irq1,
	input  logic ba,
	input  logic bs,
	output logic irq_n,
	output logic akb_b,
	gng_req_if.src req
);

	logic [1:0] irq_sync;  // irq1 comes from another board
	logic irq_prev;
	logic irq_rise;
	logic irq_ack;
	logic bus_grant;

	assign irq_rise = irq_sync[1] & ~irq_prev;

	// bs/ba decode as on the 139
	assign irq_ack = bs & ~ba;  // interrupt acknowledge
	assign bus_grant = bs & ba;

	always_ff @(posedge g6m or negedge rst_n) begin
		if (!rst_n) begin
			req.valid <= 1'b0;
			irq_sync <= 2'b00;
			irq_prev <= 1'b0;
			irq_n <= 1'b1;
			akb_b <= 1'b1;
		end else begin
			req.valid <= cpu_req;
			irq_sync <= {irq_sync[0], irq1};
			irq_prev <= irq_sync[1];
			akb_b <= ~bus_grant;
			// ack wins over a new edge
			if (irq_ack) begin
				irq_n <= 1'b1;
			end else if (irq_rise) begin
				irq_n <= 1'b0;
			end
		end
	end

	// request payload, held until the next request
	always_ff @(posedge g6m) begin
		if (cpu_req) begin
			req.addr <= cpu_addr;
			req.wdata <= cpu_wdata;
			req.rnw <= cpu_rnw;
			req.bank <= bank;
		end
	end

	// an acknowledge cycle must never see the line asserted
	a_irq_no_fall_on_ack: assert property (
		@(posedge g6m) disable iff (!rst_n)
		$fell(irq_n) |-> !$past(irq_ack)
	);

endmodule

// ==== hw/gng_addr_decode.sv ====
`timescale 1ns/1ps
`include "gng_cpu_consts.svh"

module gng_addr_decode
	import gng_cpu_pkg::*;
(
	input  logic g6m,
	input  logic rst_n,
	gng_req_if.dst req,
	gng_dec_if.src dec
);

	logic [2:0] page;  // A15..A13, the 138 select
	region_t region_nxt;
	rom_addr_t rom_nxt;

	assign page = req.addr[15:13];

	always_comb begin
		region_nxt = `RGN_OPEN;
		rom_nxt = `ROM8N_BASE;
		case (page)
			3'd0: begin
				region_nxt = `RGN_WRAM;
			end
			3'd1: begin
				region_nxt = `RGN_EXT;
			end
			3'd2: begin  // banked window 4000-5FFF
				case (req.bank)
					3'd0, 3'd1, 3'd2, 3'd3: begin
						region_nxt = `RGN_ROM;
						rom_nxt = `ROM13N_BASE +
							rom_addr_t'({req.bank[1:0], req.addr[12:0]});
					end
					3'd4: begin  // lower half of 10n
						region_nxt = `RGN_ROM;
						rom_nxt = `ROM10N_BASE + rom_addr_t'({1'b0, req.addr[12:0]});
					end
					default: begin
						region_nxt = `RGN_OPEN;  // banks 5-7 unpopulated
					end
				endcase
			end
			3'd3: begin  // fixed upper half of 10n
				region_nxt = `RGN_ROM;
				rom_nxt = `ROM10N_BASE + rom_addr_t'({1'b1, req.addr[12:0]});
			end
			default: begin  // 8000-FFFF, 8n and 9n
				region_nxt = `RGN_ROM;
				rom_nxt = `ROM8N_BASE + rom_addr_t'(req.addr[14:0]);
			end
		endcase
	end

	always_ff @(posedge g6m or negedge rst_n) begin
		if (!rst_n) begin
			dec.valid <= 1'b0;
		end else begin
			dec.valid <= req.valid;
		end
	end

	always_ff @(posedge g6m) begin
		if (req.valid) begin
			dec.region <= region_nxt;
			dec.rom_addr <= rom_nxt;
			dec.ext_addr <= req.addr[12:0];
			dec.wdata <= req.wdata;
			dec.rnw <= req.rnw;
		end
	end

	// no ROM access may fall into the gap between 10n and 13n
	a_rom_addr_range: assert property (
		@(posedge g6m) disable iff (!rst_n)
		(dec.valid && dec.region == `RGN_ROM) |->
			(dec.rom_addr < `ROM10N_END) ||
			(dec.rom_addr >= `ROM13N_BASE && dec.rom_addr < `ROM13N_END)
	);

endmodule

// ==== hw/ext_bus_driver.sv ====
`timescale 1ns/1ps
`include "gng_cpu_consts.svh"

module ext_bus_driver
	import gng_cpu_pkg::*;
(
	input  logic g6m,
	input  logic rst_n,
	gng_dec_if.dst dec,
	input  logic blcnten_b,
	input  data_t rom_data,
	input  data_t db_in,
	output ext_addr_t ab,
	output data_t db_out,
	output logic db_oe,
	output logic rdb_b,
	output logic wrb_b,
	output logic wram_b,
	output logic exten_b,
	output logic rom_rd,
	output logic cpu_rvalid,
	output data_t cpu_rdata,
	output rom_addr_t rom_addr
);

	bus_state_e state;
	bus_state_e state_nxt;
	region_t region_q;
	logic rnw_q;
	logic released_q;  // bus was given away for this item
	logic ext_hit;

	// wram and ext go through the 245 buffers
	assign ext_hit = (dec.region == `RGN_WRAM || dec.region == `RGN_EXT) && blcnten_b;

	assign state_nxt = dec.valid ? ST_STROBE : ST_IDLE;

	always_ff @(posedge g6m or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			rdb_b <= 1'b1;
			wrb_b <= 1'b1;
			wram_b <= 1'b1;
			exten_b <= 1'b1;
			db_oe <= 1'b0;
			rom_rd <= 1'b0;
		end else begin
			state <= state_nxt;
			rdb_b <= ~(dec.valid && ext_hit && dec.rnw);
			wrb_b <= ~(dec.valid && ext_hit && !dec.rnw);
			wram_b <= ~(dec.valid && blcnten_b && dec.region == `RGN_WRAM);
			exten_b <= ~(dec.valid && blcnten_b && dec.region == `RGN_EXT);
			db_oe <= dec.valid && ext_hit && !dec.rnw;
			rom_rd <= dec.valid && dec.rnw && dec.region == `RGN_ROM;  // ROM writes dropped
		end
	end

	always_ff @(posedge g6m) begin
		if (dec.valid) begin
			ab <= dec.ext_addr;
			db_out <= dec.wdata;
			rom_addr <= dec.rom_addr;
			region_q <= dec.region;
			rnw_q <= dec.rnw;
			released_q <= ~blcnten_b;
		end
	end

	assign cpu_rvalid = (state == ST_STROBE) && rnw_q;

	// read data source
	always_comb begin
		case (region_q)
			`RGN_ROM: cpu_rdata = rom_data;
			`RGN_WRAM, `RGN_EXT: cpu_rdata = released_q ? `OPEN_BUS_DATA : db_in;
			default: cpu_rdata = `OPEN_BUS_DATA;  // pull-ups on D
		endcase
	end

	a_no_rd_wr_overlap: assert property (
		@(posedge g6m) disable iff (!rst_n)
		!(!rdb_b && !wrb_b)
	);

endmodule

// ==== hw/gng_cpu_bus.sv ====
`timescale 1ns/1ps

module gng_cpu_bus
	import gng_cpu_pkg::*;
(
	input  logic g6m,
	input  logic rst_n,
	// cpu side
	input  logic cpu_req,
	input  addr_t cpu_addr,
	input  data_t cpu_wdata,
	input  logic cpu_rnw,
	output logic cpu_rvalid,
	output data_t cpu_rdata,
	input  bank_t bank,      // from 2/8
	// interrupt and bus state
	input  logic irq1,
	input  logic ba,
	input  logic bs,
	output logic irq_n,
	output logic akb_b,
	// rom chips
	output rom_addr_t rom_addr,
	output logic rom_rd,
	input  data_t rom_data,
	// board bus
	input  logic blcnten_b,
	output ext_addr_t ab,
	output data_t db_out,
	input  data_t db_in,
	output logic db_oe,
	output logic rdb_b,
	output logic wrb_b,
	output logic wram_b,
	output logic exten_b
);

	gng_req_if u_req ();
	gng_dec_if u_dec ();

	cpu_bus_capture u_capture (
		.g6m       (g6m),
		.rst_n     (rst_n),
		.cpu_req   (cpu_req),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_rnw   (cpu_rnw),
		.bank      (bank),
		.irq1      (irq1),
		.ba        (ba),
		.bs        (bs),
		.irq_n     (irq_n),
		.akb_b     (akb_b),
		.req       (u_req.src)
	);

	gng_addr_decode u_decode (
		.g6m   (g6m),
		.rst_n (rst_n),
		.req   (u_req.dst),
		.dec   (u_dec.src)
	);

	ext_bus_driver u_driver (
		.g6m        (g6m),
		.rst_n      (rst_n),
		.dec        (u_dec.dst),
		.blcnten_b  (blcnten_b),
		.rom_data   (rom_data),
		.db_in      (db_in),
		.ab         (ab),
		.db_out     (db_out),
		.db_oe      (db_oe),
		.rdb_b      (rdb_b),
		.wrb_b      (wrb_b),
		.wram_b     (wram_b),
		.exten_b    (exten_b),
		.rom_rd     (rom_rd),
		.cpu_rvalid (cpu_rvalid),
		.cpu_rdata  (cpu_rdata),
		.rom_addr   (rom_addr)
	);

endmodule

// ==== verif/gng_bus_checker.sv ====
`timescale 1ns/1ps
`include "gng_cpu_consts.svh"

module gng_bus_checker
	import gng_cpu_pkg::*;
(
	input logic g6m,
	input logic rst_n,
	input logic cpu_req,
	input addr_t cpu_addr,
	input data_t cpu_wdata,
	input logic cpu_rnw,
	input bank_t bank,
	input logic blcnten_b,
	input logic cpu_rvalid,
	input data_t cpu_rdata,
	input rom_addr_t rom_addr,
	input logic rom_rd,
	input ext_addr_t ab,
	input data_t db_out,
	input logic db_oe,
	input logic rdb_b,
	input logic wrb_b,
	input logic wram_b,
	input logic exten_b
);

	typedef struct packed {
		int unsigned cyc;
		addr_t addr;
		data_t wdata;
		logic rnw;
		bank_t bank;
		logic rel;  // board bus released
	} item_t;

	item_t q[$];
	item_t it;
	item_t r;  // request seen at the last rising edge
	logic r_req;
	int unsigned cyc = 0;
	int err_cnt;
	int chk_cnt;
	int pending;

	// expected region and unified ROM address, by CPU memory map
	function automatic void ref_map(input addr_t a, input bank_t b,
			output region_t rg, output rom_addr_t ra);
		rg = `RGN_ROM;
		ra = '0;
		if (a < 16'h2000) rg = `RGN_WRAM;
		else if (a < 16'h4000) rg = `RGN_EXT;
		else if (a < 16'h6000) begin
			if (b < 3'd4)
				ra = 17'h10000 + rom_addr_t'(b) * 17'h2000 + rom_addr_t'(a - 16'h4000);
			else if (b == 3'd4) ra = 17'h08000 + rom_addr_t'(a - 16'h4000);
			else rg = `RGN_OPEN;
		end else if (a < 16'h8000) ra = 17'h0a000 + rom_addr_t'(a - 16'h6000);
		else ra = rom_addr_t'(a - 16'h8000);
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
		chk_cnt++;
		if (exp !== got) begin
			err_cnt++;
			$display("Fail %s exp %h got %h (addr %h)", name, exp, got, it.addr);
		end
	endtask

	task automatic check_item();
		region_t rg;
		rom_addr_t ra;
		logic ext;
		data_t exp_d;
		ref_map(it.addr, it.bank, rg, ra);
		ext = (rg == `RGN_WRAM || rg == `RGN_EXT) && !it.rel;
		if (rg == `RGN_ROM) exp_d = ra[7:0] + ra[15:8] + {7'd0, ra[16]};
		else if (ext) exp_d = it.addr[7:0] ^ {3'd0, it.addr[12:8]};
		else exp_d = `OPEN_BUS_DATA;
		check("rdb_b", 32'(!(ext && it.rnw)), 32'(rdb_b));
		check("wrb_b", 32'(!(ext && !it.rnw)), 32'(wrb_b));
		check("wram_b", 32'(!(rg == `RGN_WRAM && !it.rel)), 32'(wram_b));
		check("exten_b", 32'(!(rg == `RGN_EXT && !it.rel)), 32'(exten_b));
		check("db_oe", 32'(ext && !it.rnw), 32'(db_oe));
		check("rom_rd", 32'(it.rnw && rg == `RGN_ROM), 32'(rom_rd));
		check("cpu_rvalid", 32'(it.rnw), 32'(cpu_rvalid));
		if (ext) check("ab", 32'(it.addr[12:0]), 32'(ab));
		if (ext && !it.rnw) check("db_out", 32'(it.wdata), 32'(db_out));
		if (it.rnw && rg == `RGN_ROM) check("rom_addr", 32'(ra), 32'(rom_addr));
		if (it.rnw) check("cpu_rdata", 32'(exp_d), 32'(cpu_rdata));
	endtask

	// cyc + 1 is the count seen on the next falling edge
	always @(posedge g6m) begin
		cyc <= cyc + 1;
		r_req <= cpu_req && rst_n;
		r <= '{cyc + 1, cpu_addr, cpu_wdata, cpu_rnw, bank, !blcnten_b};
	end

	// outputs only move on the rising edge, so look at them on the falling one
	always @(negedge g6m) begin
		if (!rst_n) begin
			q.delete();
		end else begin
			if (q.size() > 0 && q[0].cyc + 2 == cyc) begin
				it = q.pop_front();
				check_item();
			end else begin
				if (!rdb_b || !wrb_b || !wram_b || !exten_b || db_oe || rom_rd ||
						cpu_rvalid) begin
					err_cnt++;
					$display("bus activity at cycle %0d without a request", cyc);
				end
			end
			if (r_req) begin
				q.push_back(r);
			end
		end
		pending = q.size();
	end

	initial begin
		err_cnt = 0;
		chk_cnt = 0;
		pending = 0;
	end

endmodule

// ==== verif/tb_gng_cpu_bus.sv ====
`timescale 1ns/1ps

module tb_gng_cpu_bus
	import gng_cpu_pkg::*;
();

	logic g6m, rst_n, cpu_req, cpu_rnw, irq1, ba, bs, blcnten_b;
	addr_t cpu_addr;
	data_t cpu_wdata, cpu_rdata, rom_data, db_in, db_out;
	bank_t bank;
	logic cpu_rvalid, irq_n, akb_b, rom_rd, db_oe, rdb_b, wrb_b, wram_b, exten_b;
	rom_addr_t rom_addr;
	ext_addr_t ab;
	logic [31:0] lfsr;
	int tb_err;
	int last_err;
	int wait_n;

	gng_cpu_bus i_dut (.*);

	gng_bus_checker u_chk (.*);

	assign rom_data = rom_addr[7:0] + rom_addr[15:8] + {7'd0, rom_addr[16]};  // byte sum
	assign db_in = ab[7:0] ^ {3'd0, ab[12:8]};  // xor of address bytes

	initial begin
		g6m = 1'b0;
		forever #4 g6m = ~g6m;
	end

	// galois lfsr, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic send(input addr_t a, input logic rnw, input bank_t b);
		@(negedge g6m);
		cpu_req = 1'b1;
		cpu_addr = a;
		cpu_rnw = rnw;
		bank = b;
		cpu_wdata = data_t'(take_bits(8));
	endtask

	// end a burst and let the pipeline empty
	task automatic drain();
		@(negedge g6m);
		cpu_req = 1'b0;
		wait_n = 0;
		while (u_chk.pending != 0 || wait_n < 3) begin
			@(negedge g6m);
			wait_n++;
			if (wait_n > 20) begin
				$display("pipeline did not drain");
				$display("RESULT: FAIL");
				$finish;
			end
		end
	endtask

	// counters move on the falling edge
	task automatic report(input string name);
		int e;
		@(posedge g6m);
		e = u_chk.err_cnt + tb_err;
		if (e == last_err) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: failed (%0d errors)", name, e - last_err);
		end
		last_err = e;
	endtask

	// wait up to n cycles for sig to reach val
	task automatic wait_level(ref logic sig, input logic val, input int n, input string what);
		wait_n = 0;
		while (sig !== val && wait_n < n) begin
			@(negedge g6m);
			wait_n++;
		end
		if (sig !== val) begin
			tb_err++;
			$display("%s did not happen within %0d cycles", what, n);
		end
	endtask

	initial begin
		{rst_n, cpu_req, cpu_rnw, irq1, ba, bs} = '0;
		{cpu_addr, cpu_wdata, bank} = '0;
		blcnten_b = 1'b1;
		lfsr = 32'hab7b5493;
		tb_err = 0;
		last_err = 0;
		repeat (2) @(posedge g6m);
		@(negedge g6m);
		rst_n = 1'b1;
		if ({irq_n, akb_b, rdb_b, wrb_b, wram_b, exten_b, db_oe, rom_rd, cpu_rvalid}
				!== 9'b111111000) begin
			tb_err++;
			$display("outputs not inactive after reset");
		end

		for (int i = 0; i < 16; i++) begin
			if (take_bits(1) != 0)
				send(16'h8000 | addr_t'(take_bits(15)), 1'b1, 3'd0);
			else
				send(16'h6000 | addr_t'(take_bits(13)), 1'b1, 3'd0);
		end
		drain();
		report("rom_reads");

		for (int b = 0; b < 8; b++)
			send(16'h4000 | addr_t'(take_bits(13)), 1'b1, bank_t'(b));
		drain();
		report("bank_sweep");

		for (int i = 0; i < 8; i++) begin
			addr_t a;
			a = {2'b00, i[0], ext_addr_t'(take_bits(13))};  // wram or ext page
			send(a, 1'b0, 3'd0);
			send(a, 1'b1, 3'd0);
		end
		drain();
		report("wram_ext");

		for (int i = 0; i < 40; i++)
			send(addr_t'(take_bits(16)), 1'(take_bits(1)), bank_t'(take_bits(3)));
		drain();
		report("back_to_back");

		@(negedge g6m);
		blcnten_b = 1'b0;
		for (int i = 0; i < 24; i++)
			send(addr_t'(take_bits(16)), 1'(take_bits(1)), bank_t'(take_bits(3)));
		drain();
		blcnten_b = 1'b1;
		report("bus_released");

		@(negedge g6m);
		irq1 = 1'b1;
		wait_level(irq_n, 1'b0, 4, "irq_n low after irq1");
		irq1 = 1'b0;
		repeat (5) begin
			@(negedge g6m);
			if (irq_n !== 1'b0) begin
				tb_err++;
				$display("irq_n released before acknowledge");
			end
		end
		bs = 1'b1;  // acknowledge, ba stays low
		wait_level(irq_n, 1'b1, 3, "irq_n high after acknowledge");
		ba = 1'b1;
		wait_level(akb_b, 1'b0, 3, "akb_b low on bus grant");
		{bs, ba} = 2'b00;
		wait_level(akb_b, 1'b1, 3, "akb_b high after bus grant");
		report("irq_ack");

		$display("checks %0d, errors %0d", u_chk.chk_cnt, u_chk.err_cnt + tb_err);
		if (u_chk.err_cnt + tb_err == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+hw
hw/gng_cpu_pkg.sv
hw/gng_bus_if.sv
hw/cpu_bus_capture.sv
hw/gng_addr_decode.sv
hw/ext_bus_driver.sv
hw/gng_cpu_bus.sv
verif/gng_bus_checker.sv
verif/tb_gng_cpu_bus.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_gng_cpu_bus
RTL_TOP   ?= gng_cpu_bus
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
